// ==== rtl/blit_pkg.sv ====
`default_nettype none

package blit_pkg;

  // display and sprite geometry
  localparam int screen_w = 320;
  localparam int screen_h = 240;
  localparam int sprite_w = 8;
  localparam int sprite_h = 8;
  localparam int sprite_count = 4;
  localparam int sprite_col_bits = $clog2(sprite_w);
  localparam int sprite_row_bits = $clog2(sprite_h);

  // pixel codes, 2 bits each
  localparam logic [1:0] px_transparent = 2'd2;
  localparam logic [1:0] px_ink = 2'd1;

  // one rom word per sprite row
  localparam int row_bits = 16;
  localparam int rom_addr_bits = 5;

  localparam int fifo_depth = 4;
  localparam int fifo_ptr_bits = $clog2(fifo_depth);

  // register byte offsets
  localparam logic [7:0] reg_ctrl = 8'h00;
  localparam logic [7:0] reg_pos = 8'h04;
  localparam logic [7:0] reg_status = 8'h08;

  localparam logic [1:0] resp_okay = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [8:0] x;
    logic [7:0] y;
    logic       colour;
  } pixel_write_t;

  typedef struct packed {
    logic [1:0] sprite_id;
    logic [8:0] base_x;
    logic [7:0] base_y;
  } draw_cmd_t;

endpackage

`default_nettype wire

// ==== rtl/blit_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module blit_regs (
  input  wire                 clk,
  input  wire                 reset,
  input  wire  [7:0]          awaddr,
  input  wire                 awvalid,
  output logic                awready,
  input  wire  [31:0]         wdata,
  input  wire  [3:0]          wstrb,
  input  wire                 wvalid,
  output logic                wready,
  output logic [1:0]          bresp,
  output logic                bvalid,
  input  wire                 bready,
  input  wire  [7:0]          araddr,
  input  wire                 arvalid,
  output logic                arready,
  output logic [31:0]         rdata,
  output logic [1:0]          rresp,
  output logic                rvalid,
  input  wire                 rready,
  input  wire                 busy,
  input  wire                 done,
  output logic                start,
  output blit_pkg::draw_cmd_t cmd
);
  import blit_pkg::*;

  logic        wr_accept;
  logic        wr_fire;
  logic        wr_mapped;
  logic        start_req;
  logic        start_blocked;
  logic        rd_fire;
  logic        rd_mapped;
  logic [31:0] rd_word;
  logic [7:0]  done_count;

  // address and data are taken together in one cycle
  assign awready = wr_accept;
  assign wready = wr_accept;
  assign wr_fire = wr_accept && awvalid && wvalid;
  assign rd_fire = arready && arvalid;

  assign wr_mapped = (awaddr == reg_ctrl) || (awaddr == reg_pos) || (awaddr == reg_status);
  assign start_req = wr_fire && (awaddr == reg_ctrl) && wstrb[1] && wdata[8];
  // start is already on its way while the renderer has not raised busy yet
  assign start_blocked = busy || start;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_accept <= 1'b0;
      bvalid <= 1'b0;
      bresp <= resp_okay;
      start <= 1'b0;
      cmd <= '0;
    end else begin
      wr_accept <= awvalid && wvalid && !wr_accept && !bvalid;
      start <= start_req && !start_blocked;
      if (wr_fire) begin
        bvalid <= 1'b1;
        if (!wr_mapped || (start_req && start_blocked)) begin
          bresp <= resp_slverr;
        end else begin
          bresp <= resp_okay;
        end
        case (awaddr)
          reg_ctrl: begin
            // sprite id is stored even when the start is refused
            if (wstrb[0]) begin
              cmd.sprite_id <= wdata[1:0];
            end
          end
          reg_pos: begin
            if (wstrb[0]) begin
              cmd.base_x[7:0] <= wdata[7:0];
            end
            if (wstrb[1]) begin
              cmd.base_x[8] <= wdata[8];
            end
            if (wstrb[2]) begin
              cmd.base_y <= wdata[23:16];
            end
          end
          default: begin
          end
        endcase
      end else if (bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // completed draws, wraps at 256
  always_ff @(posedge clk) begin
    if (reset) begin
      done_count <= 8'd0;
    end else if (done) begin
      done_count <= done_count + 8'd1;
    end
  end

  always_comb begin
    rd_mapped = 1'b1;
    case (araddr)
      reg_ctrl: rd_word = {30'd0, cmd.sprite_id};
      reg_pos: rd_word = {8'h00, cmd.base_y, 7'h00, cmd.base_x};
      reg_status: rd_word = {16'h0000, done_count, 7'h00, busy};
      default: begin
        rd_word = 32'd0;
        rd_mapped = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      arready <= 1'b0;
      rvalid <= 1'b0;
    end else begin
      arready <= arvalid && !arready && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // read payload, captured at the address handshake
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_word;
      rresp <= rd_mapped ? resp_okay : resp_slverr;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sprite_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_rom (
  input  wire                                clk,
  input  wire  [blit_pkg::rom_addr_bits-1:0] rom_addr,
  output logic [blit_pkg::row_bits-1:0]      rom_row
);
  import blit_pkg::*;

  // address is {sprite id, row}, column 0 in bits 1:0
  logic [row_bits-1:0] rows [sprite_count*sprite_h];

  initial begin
    $readmemh("sprites.hex", rows);
  end

  always_ff @(posedge clk) begin
    rom_row <= rows[rom_addr];
  end

endmodule

`default_nettype wire

// ==== rtl/sprite_render.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_render (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                start,
  input  wire  blit_pkg::draw_cmd_t          cmd,
  output logic                               busy,
  output logic                               done,
  output logic [blit_pkg::rom_addr_bits-1:0] rom_addr,
  input  wire  [blit_pkg::row_bits-1:0]      rom_row,
  output logic                               push_valid,
  output blit_pkg::pixel_write_t             push_data,
  input  wire                                push_ready
);
  import blit_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_fetch,
    st_emit,
    st_finish
  } state_t;

  state_t                     state;
  draw_cmd_t                  cur;
  logic [sprite_row_bits-1:0] row;
  logic [sprite_col_bits-1:0] col;
  logic [1:0]                 code;
  logic [9:0]                 px_x;
  logic [8:0]                 px_y;
  logic                       visible;
  logic                       advance;
  logic                       last_col;
  logic                       last_row;

  // row 0 is read in the start cycle itself, later rows go through fetch
  assign rom_addr = (state == st_idle) ? {cmd.sprite_id, {sprite_row_bits{1'b0}}}
                                       : {cur.sprite_id, row};

  assign code = rom_row[{col, 1'b0} +: 2];

  // one bit wider than the screen so that wrap-around clips too
  assign px_x = {1'b0, cur.base_x} + 10'(col);
  assign px_y = {1'b0, cur.base_y} + 9'(row);

  assign visible = (code != px_transparent) && (px_x < 10'(screen_w)) &&
                   (px_y < 9'(screen_h));

  assign push_valid = (state == st_emit) && visible;

  always_comb begin
    push_data.x = px_x[8:0];
    push_data.y = px_y[7:0];
    // codes 0 and 3 both end up as colour 0
    push_data.colour = (code == px_ink);
  end

  // hidden pixels step on at once, drawn ones wait for room in the fifo
  assign advance = (state == st_emit) && (!visible || push_ready);
  assign last_col = (col == sprite_col_bits'(sprite_w - 1));
  assign last_row = (row == sprite_row_bits'(sprite_h - 1));

  assign busy = (state == st_fetch) || (state == st_emit);
  assign done = (state == st_finish);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      row <= '0;
      col <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_emit;
            row <= '0;
            col <= '0;
          end
        end
        st_fetch: begin
          state <= st_emit;
        end
        st_emit: begin
          if (advance) begin
            if (last_col) begin
              col <= '0;
              if (last_row) begin
                state <= st_finish;
              end else begin
                row <= row + 1'b1;
                state <= st_fetch;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        st_finish: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // command held for the whole draw
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      cur <= cmd;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/pixel_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_fifo (
  input  wire                     clk,
  input  wire                     reset,
  input  wire                     push_valid,
  input  wire blit_pkg::pixel_write_t push_data,
  output logic                    push_ready,
  output logic                    fb_valid,
  output blit_pkg::pixel_write_t  fb_data,
  input  wire                     fb_ready
);
  import blit_pkg::*;

  pixel_write_t             slots [fifo_depth];
  logic [fifo_ptr_bits-1:0] wr_ptr;
  logic [fifo_ptr_bits-1:0] rd_ptr;
  logic [fifo_ptr_bits:0]   fill;
  logic                     do_push;
  logic                     do_pop;

  assign push_ready = (fill != (fifo_ptr_bits + 1)'(fifo_depth));
  assign fb_valid = (fill != '0);
  // head entry straight from the storage registers
  assign fb_data = slots[rd_ptr];

  assign do_push = push_valid && push_ready;
  assign do_pop = fb_valid && fb_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop keeps the fill level
      case ({do_push, do_pop})
        2'b10: fill <= fill + 1'b1;
        2'b01: fill <= fill - 1'b1;
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      slots[wr_ptr] <= push_data;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/sprite_blitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module sprite_blitter (
  input  wire                    clk,
  input  wire                    reset,
  input  wire  [7:0]             awaddr,
  input  wire                    awvalid,
  output logic                   awready,
  input  wire  [31:0]            wdata,
  input  wire  [3:0]             wstrb,
  input  wire                    wvalid,
  output logic                   wready,
  output logic [1:0]             bresp,
  output logic                   bvalid,
  input  wire                    bready,
  input  wire  [7:0]             araddr,
  input  wire                    arvalid,
  output logic                   arready,
  output logic [31:0]            rdata,
  output logic [1:0]             rresp,
  output logic                   rvalid,
  input  wire                    rready,
  output logic                   fb_valid,
  output blit_pkg::pixel_write_t fb_data,
  input  wire                    fb_ready
);
  import blit_pkg::*;

  logic                     start;
  logic                     busy;
  logic                     done;
  draw_cmd_t                cmd;
  logic [rom_addr_bits-1:0] rom_addr;
  logic [row_bits-1:0]      rom_row;
  logic                     push_valid;
  logic                     push_ready;
  pixel_write_t             push_data;

  // host side
  blit_regs i_regs (
    .clk(clk), .reset(reset),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .bresp(bresp), .bvalid(bvalid), .bready(bready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready),
    .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
    .busy(busy), .done(done), .start(start), .cmd(cmd)
  );

  sprite_rom i_rom (.clk(clk), .rom_addr(rom_addr), .rom_row(rom_row));

  sprite_render i_render (
    .clk(clk), .reset(reset), .start(start), .cmd(cmd),
    .busy(busy), .done(done), .rom_addr(rom_addr), .rom_row(rom_row),
    .push_valid(push_valid), .push_data(push_data), .push_ready(push_ready)
  );

  // framebuffer side
  pixel_fifo i_fifo (
    .clk(clk), .reset(reset),
    .push_valid(push_valid), .push_data(push_data), .push_ready(push_ready),
    .fb_valid(fb_valid), .fb_data(fb_data), .fb_ready(fb_ready)
  );

endmodule

`default_nettype wire

// ==== tb/tb_sprite_blitter.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_blitter;
  import blit_pkg::*;

  typedef struct packed {
    int id;
    int bx;
    int by;
    bit rnd;
    bit restart;
  } draw_case_t;

  localparam int num_cases = 7;
  localparam int watchdog_ns = num_cases * 64 * 20 * 8 + 2000;

  logic         clk = 1'b0;
  logic         reset;
  logic [7:0]   awaddr;
  logic         awvalid;
  logic         awready;
  logic [31:0]  wdata;
  logic [3:0]   wstrb;
  logic         wvalid;
  logic         wready;
  logic [1:0]   bresp;
  logic         bvalid;
  logic         bready;
  logic [7:0]   araddr;
  logic         arvalid;
  logic         arready;
  logic [31:0]  rdata;
  logic [1:0]   rresp;
  logic         rvalid;
  logic         rready;
  logic         fb_valid;
  pixel_write_t fb_data;
  logic         fb_ready = 1'b1;

  logic [row_bits-1:0] model_rom [sprite_count*sprite_h];
  draw_case_t          cases [num_cases];
  pixel_write_t        got_q [$];
  pixel_write_t        exp_q [$];
  bit                  rand_ready = 1'b0;
  int                  idle_cycles = 0;
  int                  errors = 0;
  int                  tests_run = 0;
  int                  tests_failed = 0;
  int                  exp_count = 0;

  sprite_blitter i_dut (.*);

  initial begin
    forever #4 clk = ~clk;
  end

  // fb_ready pattern and capture of each framebuffer write
  always @(negedge clk) begin
    if (rand_ready) begin
      fb_ready = 1'($urandom % 2);
    end else begin
      fb_ready = 1'b1;
    end
    // this transfer happens at the coming rising edge
    if (fb_valid && fb_ready) begin
      got_q.push_back(fb_data);
      idle_cycles = 0;
    end else if (idle_cycles < 1000) begin
      idle_cycles++;
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_test(input string name, input int err_mark);
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - err_mark);
    end
  endtask

  task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                           output logic [1:0] resp);
    @(negedge clk);
    awaddr = addr;
    wdata = data;
    awvalid = 1'b1;
    wvalid = 1'b1;
    @(negedge clk);
    while (!awready) @(negedge clk);
    // address and data are accepted together
    check("wready", 32'(wready), 32'h1);
    // handshake taken at the edge just passed
    @(negedge clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    while (!bvalid) @(negedge clk);
    resp = bresp;
  endtask

  task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    @(negedge clk);
    araddr = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(negedge clk);
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    data = rdata;
    resp = rresp;
  endtask

  // reference model walking the sprite in row-major order
  task automatic build_expected(input int id, input int bx, input int by);
    logic [1:0]   code;
    pixel_write_t pw;
    int           x;
    int           y;
    exp_q.delete();
    for (int r = 0; r < sprite_h; r++) begin
      for (int c = 0; c < sprite_w; c++) begin
        code = model_rom[id * sprite_h + r][2 * c +: 2];
        x = bx + c;
        y = by + r;
        if (code != 2'd2 && x < screen_w && y < screen_h) begin
          pw.x = 9'(x);
          pw.y = 8'(y);
          pw.colour = (code == 2'd1);
          exp_q.push_back(pw);
        end
      end
    end
  endtask

  task automatic run_case(input int n);
    draw_case_t  tc;
    logic [31:0] pos;
    logic [31:0] data;
    logic [1:0]  resp;
    int          err_mark;
    tc = cases[n];
    err_mark = errors;
    rand_ready = tc.rnd;
    pos = (32'(tc.by) << 16) | 32'(tc.bx);
    axi_write(reg_pos, pos, resp);
    check("bresp pos", 32'(resp), 32'(resp_okay));
    axi_read(reg_pos, data, resp);
    check("rdata pos", data, pos);
    got_q.delete();
    axi_write(reg_ctrl, 32'h100 | 32'(tc.id), resp);
    check("bresp start", 32'(resp), 32'(resp_okay));
    if (tc.restart) begin
      axi_write(reg_ctrl, 32'h100 | 32'(tc.id), resp);
      check("bresp restart", 32'(resp), 32'(resp_slverr));
    end
    exp_count = (exp_count + 1) % 256;
    // wait for done with the fifo drained and the output quiet for twenty cycles
    do begin
      axi_read(reg_status, data, resp);
    end while (data[0] || data[15:8] == 8'(exp_count - 1) || fb_valid || idle_cycles < 20);
    check("status count", 32'(data[15:8]), 32'(exp_count));
    build_expected(tc.id, tc.bx, tc.by);
    check("pixel count", got_q.size(), exp_q.size());
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check("fb_data", 32'(got_q[i]), 32'(exp_q[i]));
    end
    report_test($sformatf("draw %0d sprite %0d at %0d,%0d", n, tc.id, tc.bx, tc.by), err_mark);
  endtask

  initial begin
    logic [31:0] data;
    logic [1:0]  resp;
    int          err_mark;
    void'($urandom(32'hdf6d));
    $readmemh("sprites.hex", model_rom);
    cases[0] = '{0, 10, 20, 1'b0, 1'b0};
    cases[1] = '{1, 100, 50, 1'b0, 1'b0};
    cases[2] = '{2, 40, 40, 1'b0, 1'b0};
    cases[3] = '{3, 316, 236, 1'b0, 1'b0};
    cases[4] = '{0, 200, 100, 1'b1, 1'b0};
    cases[5] = '{3, 5, 7, 1'b1, 1'b1};
    cases[6] = '{1, 316, 236, 1'b1, 1'b0};
    reset = 1'b1;
    awaddr = 8'h00;
    awvalid = 1'b0;
    wdata = 32'h0;
    wstrb = 4'hf;
    wvalid = 1'b0;
    bready = 1'b1;
    araddr = 8'h00;
    arvalid = 1'b0;
    rready = 1'b1;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    err_mark = errors;
    axi_read(reg_status, data, resp);
    check("status after reset", data, 32'h0);
    check("rresp status", 32'(resp), 32'(resp_okay));
    report_test("status after reset", err_mark);

    for (int n = 0; n < num_cases; n++) begin
      run_case(n);
    end

    err_mark = errors;
    axi_write(8'd12, 32'h1234, resp);
    check("bresp offset 12", 32'(resp), 32'(resp_slverr));
    axi_read(8'd12, data, resp);
    check("rresp offset 12", 32'(resp), 32'(resp_slverr));
    check("rdata offset 12", data, 32'h0);
    report_test("unmapped offset", err_mark);

    $display("tests run %0d, failed %0d, mismatches %0d", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("timeout: run still going after %0d ns", watchdog_ns);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
rtl/blit_pkg.sv
rtl/blit_regs.sv
rtl/sprite_rom.sv
rtl/sprite_render.sv
rtl/pixel_fifo.sv
rtl/sprite_blitter.sv
tb/tb_sprite_blitter.sv

// ==== run.sh ====
#!/usr/bin/env bash
# run from the project root so that sprites.hex is found by both ROMs
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_sprite_blitter -f flist.f -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || echo "build or simulation did not complete"
if [ -f sim.log ]; then
  cat sim.log
fi
grep -qx "Verification passed" sim.log && exit 0 || exit 1

// ==== sprites.hex ====
// one 16-bit row word per line, sprite 0 rows 0 to 7 first, then sprites 1 to 3
// column c sits in bits 2c+1:2c, code 1 is ink, code 2 is transparent
5555
9669
a5a5
0f0f
f0f0
6996
1248
8421
55aa
aa55
1111
2222
3333
4444
c3c3
3c3c
aaaa
aaaa
aaaa
aaaa
aaaa
aaaa
aaaa
aaaa
0000
ffff
5a5a
a5a5
1e1e
e1e1
7777
9999
